/* verilog.f */
scope_pkg.sv
video_timing.sv
trace_buffer.sv
sample_measure.sv
trace_overlay.sv
scope_display_top.sv
tb_scope_display.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_scope_display
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
SRCS       ?= $(wildcard *.sv)

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a $$fatal in the testbench gives a non-zero exit status
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb_scope_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scope_display;

    import scope_pkg::*;

    localparam int      CLK_PERIOD      = 4;
    localparam int      RESET_CYCLES    = 16;
    localparam int      HALF_PERIOD     = 16;  // square wave half period in samples
    localparam int      SQ_SAMPLES      = 4 * MEAS_WINDOW;
    localparam int      SQ_LAST_WIN     = 4;  // windows 2..4 hold only square samples
    localparam int      PIXELS          = H_ACT * V_ACT;
    localparam int      WATCHDOG_CYCLES = 4 * H_TOTAL * V_TOTAL + 3 * MEAS_WINDOW;
    localparam sample_t SQ_LOW          = 8'd50;
    localparam sample_t SQ_HIGH         = 8'd200;
    localparam meas_t   SQ_MEAS = {SQ_HIGH, SQ_LOW, CNT_W'(MEAS_WINDOW / (2 * HALF_PERIOD))};

    typedef enum logic [1:0] {MODE_IDLE, MODE_FILL, MODE_SQUARE, MODE_RANDOM} stim_mode_t;

    logic    cfg_clk        = 1'b0;
    logic    i_reset;
    logic    i_sample_valid = 1'b0;
    sample_t i_sample       = '0;
    logic    i_freeze       = 1'b0;
    page_t   i_page;
    video_t  o_video;
    meas_t   o_meas;
    logic    o_meas_valid;

    integer      seed      = 32'h7293_3cfc;
    logic [31:0] rnd;
    logic        in_reset;
    stim_mode_t  stim_mode = MODE_IDLE;
    int          stim_cnt  = 0;
    sample_t     captured [H_ACT];  // what the frozen screen should show

    logic        armed       = 1'b0;
    int          post_rst    = 0;
    int          m_h         = 0;
    int          m_v         = 0;
    logic [2:0]  sync_d1     = '0;
    logic [2:0]  sync_d2     = '0;
    logic [2:0]  dut_sync;
    logic [3:0]  quiet_bits;
    logic        vs_q        = 1'b0;
    int          ox          = 0;
    int          oy          = 0;
    logic        frame_check = 1'b0;
    page_t       check_page  = PAGE_WAVE;
    pixel_t      exp_rgb;
    int          wave_px     = 0;
    int          main_px     = 0;

    sample_t          win_buf [MEAS_WINDOW];
    int               win_fill       = 0;
    sample_t          last_sample    = '0;
    sample_t          start_prev;
    sample_t          w_max;
    sample_t          w_min;
    sample_t          w_prev;
    logic [CNT_W-1:0] w_cross;
    meas_t            exp_meas       = '0;
    logic             exp_meas_valid = 1'b0;
    int               win_idx        = 0;

    scope_display_top scope_display_top_inst (
        .cfg_clk        (cfg_clk),
        .i_reset        (i_reset),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_freeze       (i_freeze),
        .i_page         (i_page),
        .o_video        (o_video),
        .o_meas         (o_meas),
        .o_meas_valid   (o_meas_valid)
    );

    always #(CLK_PERIOD / 2) cfg_clk = ~cfg_clk;

    function automatic logic [2:0] raster_sync(input int h, input int v);
        logic de;
        logic hs;
        logic vs;
        de = (h < H_ACT) && (v < V_ACT);
        hs = (h >= H_ACT + H_FP) && (h < H_ACT + H_FP + H_SYNC);
        vs = (v >= V_ACT + V_FP) && (v < V_ACT + V_FP + V_SYNC);  // whole lines
        return {vs, hs, de};
    endfunction

    function automatic pixel_t pixel_rule(input logic de, input page_t page,
                                          input int x, input int y, input sample_t s);
        int row;
        row = (255 - int'(s)) >> ROW_SHIFT;
        if (!de)
        begin
            return '0;
        end
        if (page == PAGE_MAIN)
        begin
            return COLOR_MAIN;
        end
        if (y == row)
        begin
            return COLOR_TRACE;
        end
        if ((x % GRID_STEP == 0) || (y % GRID_STEP == 0))
        begin
            return COLOR_GRID;
        end
        return COLOR_BG;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("Mismatch %s expected %0h actual %0h",
                                    test, expected, actual));
    endtask

    task automatic wait_vsync_rise();
        @(posedge cfg_clk);
        while (!(o_video.vs && !vs_q))
        begin
            @(posedge cfg_clk);
        end
    endtask

    // sample source, inputs change 1 ns after the edge
    always @(posedge cfg_clk)
    begin
        in_reset = i_reset;
        #1;
        rnd = $random(seed);
        case (stim_mode)
            MODE_IDLE:
            begin
                i_sample_valid = 1'b0;
                if (!in_reset)
                begin
                    stim_mode = MODE_FILL;
                end
            end
            MODE_FILL:
            begin
                i_sample_valid     = 1'b1;
                i_sample           = rnd[7:0];
                captured[stim_cnt] = rnd[7:0];  // column stim_cnt
                stim_cnt++;
                if (stim_cnt == H_ACT)
                begin
                    stim_mode = MODE_SQUARE;
                    stim_cnt  = 0;
                end
            end
            MODE_SQUARE:
            begin
                i_freeze       = 1'b1;  // buffer is full, hold it
                i_sample_valid = 1'b1;
                i_sample       = ((stim_cnt / HALF_PERIOD) % 2 == 0) ? SQ_LOW : SQ_HIGH;
                stim_cnt++;
                if (stim_cnt == SQ_SAMPLES)
                begin
                    stim_mode = MODE_RANDOM;
                end
            end
            default:
            begin
                i_sample_valid = (rnd[9:8] != 2'b00);  // about three cycles in four
                i_sample       = rnd[7:0];
            end
        endcase
    end

    always @(posedge cfg_clk)
    begin
        if (i_reset)
        begin
            armed    <= (post_rst != 0);  // outputs are known from the second reset edge
            post_rst <= 2;  // pipeline refill
        end
        else if (post_rst != 0)
        begin
            post_rst <= post_rst - 1;
        end
    end

    // expected sync, two cycles behind the raster position
    always @(posedge cfg_clk)
    begin
        if (i_reset)
        begin
            m_h     <= 0;
            m_v     <= 0;
            sync_d1 <= '0;
            sync_d2 <= '0;
        end
        else
        begin
            sync_d1 <= raster_sync(m_h, m_v);
            sync_d2 <= sync_d1;
            if (m_h == H_TOTAL - 1)
            begin
                m_h <= 0;
                m_v <= (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end
            else
            begin
                m_h <= m_h + 1;
            end
        end
    end

    // pixel position from the output stream itself
    always @(posedge cfg_clk)
    begin
        vs_q <= o_video.vs;
        if (o_video.vs)
        begin
            ox <= 0;
            oy <= 0;
        end
        else if (o_video.de)
        begin
            ox <= (ox == H_ACT - 1) ? 0 : ox + 1;
            oy <= (ox == H_ACT - 1) ? oy + 1 : oy;
        end
        if (frame_check && o_video.de)
        begin
            if (check_page == PAGE_WAVE)
            begin
                wave_px <= wave_px + 1;
            end
            else
            begin
                main_px <= main_px + 1;
            end
        end
    end

    // window results rebuilt from the stored samples
    always @(posedge cfg_clk)
    begin
        exp_meas_valid <= 1'b0;
        if (i_reset)
        begin
            win_fill    = 0;
            last_sample = '0;
            exp_meas   <= '0;
            win_idx    <= 0;
        end
        else if (i_sample_valid)
        begin
            if (win_fill == 0)
            begin
                start_prev = last_sample;  // carried from the last window
            end
            win_buf[win_fill] = i_sample;
            win_fill++;
            last_sample = i_sample;
            if (win_fill == MEAS_WINDOW)
            begin
                w_max   = 8'd0;
                w_min   = 8'd255;
                w_cross = '0;
                w_prev  = start_prev;
                for (int k = 0; k < MEAS_WINDOW; k++)
                begin
                    w_max = (win_buf[k] > w_max) ? win_buf[k] : w_max;
                    w_min = (win_buf[k] < w_min) ? win_buf[k] : w_min;
                    if (win_buf[k] >= sample_t'(MID_LEVEL) && w_prev < sample_t'(MID_LEVEL))
                    begin
                        w_cross = w_cross + 1'b1;
                    end
                    w_prev = win_buf[k];
                end
                exp_meas       <= {w_max, w_min, w_cross};
                exp_meas_valid <= 1'b1;
                win_idx        <= win_idx + 1;
                win_fill        = 0;
            end
        end
    end

    assign dut_sync   = {o_video.vs, o_video.hs, o_video.de};
    assign quiet_bits = {o_video.vs, o_video.hs, o_video.de, o_meas_valid};
    assign exp_rgb    = pixel_rule(o_video.de, check_page, ox, oy, captured[ox % H_ACT]);

    a_reset_quiet: assert property (@(posedge cfg_clk) (post_rst != 0) |-> (quiet_bits == '0))
        else report_mismatch("reset", 32'd0, 32'($sampled(quiet_bits)));

    a_raster: assert property (@(posedge cfg_clk) disable iff (!armed) dut_sync == sync_d2)
        else report_mismatch("raster", 32'($sampled(sync_d2)), 32'($sampled(dut_sync)));

    a_pixel: assert property (
        @(posedge cfg_clk) disable iff (!armed)
        frame_check |-> (o_video.rgb == exp_rgb)
    ) else report_mismatch("pixel", 32'($sampled(exp_rgb)), 32'($sampled(o_video.rgb)));

    a_meas_strobe: assert property (
        @(posedge cfg_clk) disable iff (!armed)
        o_meas_valid == exp_meas_valid
    ) else report_mismatch("meas_valid", 32'($sampled(exp_meas_valid)),
                           32'($sampled(o_meas_valid)));

    a_meas_value: assert property (
        @(posedge cfg_clk) disable iff (!armed)
        o_meas_valid |-> (o_meas == exp_meas)
    ) else report_mismatch("meas_window", 32'($sampled(exp_meas)), 32'($sampled(o_meas)));

    // square wave windows have fixed results
    a_meas_square: assert property (
        @(posedge cfg_clk) disable iff (!armed)
        (o_meas_valid && win_idx >= 2 && win_idx <= SQ_LAST_WIN) |-> (o_meas == SQ_MEAS)
    ) else report_mismatch("meas_square", 32'(SQ_MEAS), 32'($sampled(o_meas)));

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure($sformatf("timeout after %0d cycles", WATCHDOG_CYCLES));
    end

    initial
    begin
        i_reset = 1'b1;
        i_page  = PAGE_WAVE;
        repeat (RESET_CYCLES) @(posedge cfg_clk);
        #1;
        i_reset = 1'b0;
        while (!i_freeze)
        begin
            @(posedge cfg_clk);
        end
        wait_vsync_rise();
        #1;
        frame_check = 1'b1;  // one frozen waveform frame
        wait_vsync_rise();
        #1;
        i_page     = PAGE_MAIN;
        check_page = PAGE_MAIN;
        wait_vsync_rise();
        #1;
        frame_check = 1'b0;
        if (wave_px == PIXELS && main_px == PIXELS && win_idx > SQ_LAST_WIN + 1)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            stop_with_failure($sformatf("too little checked: wave %0d main %0d windows %0d",
                                        wave_px, main_px, win_idx));
        end
    end

endmodule

`default_nettype wire

/* scope_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scope_display_top (
    input  wire                 cfg_clk,
    input  wire                 i_reset,
    input  logic                i_sample_valid,
    input  scope_pkg::sample_t  i_sample,
    input  logic                i_freeze,
    input  scope_pkg::page_t    i_page,
    output scope_pkg::video_t   o_video,
    output scope_pkg::meas_t    o_meas,
    output logic                o_meas_valid
);

    import scope_pkg::*;

    timing_t timing;
    coord_t  rd_addr;
    sample_t rd_sample;

    video_timing u_video_timing (
        .cfg_clk        (cfg_clk),
        .i_reset        (i_reset),
        .o_timing       (timing)
    );

    trace_buffer u_trace_buffer (
        .cfg_clk        (cfg_clk),
        .i_reset        (i_reset),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_freeze       (i_freeze),
        .i_rd_addr      (rd_addr),
        .o_rd_sample    (rd_sample)
    );

    trace_overlay u_trace_overlay (
        .cfg_clk        (cfg_clk),
        .i_reset        (i_reset),
        .i_timing       (timing),
        .i_page         (i_page),
        .o_rd_addr      (rd_addr),
        .i_rd_sample    (rd_sample),
        .o_video        (o_video)
    );

    // runs beside the video chain on the same stream
    sample_measure u_sample_measure (
        .cfg_clk        (cfg_clk),
        .i_reset        (i_reset),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .o_meas         (o_meas),
        .o_meas_valid   (o_meas_valid)
    );

endmodule

`default_nettype wire

/* trace_overlay.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_overlay (
    input  wire                 cfg_clk,
    input  wire                 i_reset,
    input  scope_pkg::timing_t  i_timing,
    input  scope_pkg::page_t    i_page,
    output scope_pkg::coord_t   o_rd_addr,
    input  scope_pkg::sample_t  i_rd_sample,
    output scope_pkg::video_t   o_video
);

    import scope_pkg::*;

    timing_t tim_q;  // timing aligned with buffer read data
    page_t   page_q;
    sample_t inv_sample;
    coord_t  trace_row;
    logic    on_grid;
    video_t  video_d;

    assign o_rd_addr = i_timing.x;  // column lookup

    // stage 1, wait for the buffer read
    always_ff @(posedge cfg_clk)
    begin
        if (i_reset)
        begin
            tim_q  <= '0;
            page_q <= PAGE_MAIN;
        end
        else
        begin
            tim_q  <= i_timing;
            page_q <= i_page;
        end
    end

    always_comb
    begin
        // top of screen is full scale
        inv_sample = sample_t'(255) - i_rd_sample;
        trace_row  = coord_t'(inv_sample >> ROW_SHIFT);
        on_grid    = ((tim_q.x % coord_t'(GRID_STEP)) == '0) ||
                     ((tim_q.y % coord_t'(GRID_STEP)) == '0);

        video_d.vs = tim_q.vs;
        video_d.hs = tim_q.hs;
        video_d.de = tim_q.de;
        if (!tim_q.de)
        begin
            video_d.rgb = '0;  // blanking is black
        end
        else if (page_q == PAGE_MAIN)
        begin
            video_d.rgb = COLOR_MAIN;
        end
        else if (tim_q.y == trace_row)
        begin
            video_d.rgb = COLOR_TRACE;  // trace drawn over grid
        end
        else if (on_grid)
        begin
            video_d.rgb = COLOR_GRID;
        end
        else
        begin
            video_d.rgb = COLOR_BG;
        end
    end

    // stage 2, colour and sync leave together
    always_ff @(posedge cfg_clk)
    begin
        if (i_reset)
        begin
            o_video <= '0;
        end
        else
        begin
            o_video <= video_d;
        end
    end

    // every active column has a slot in the trace buffer
    a_active_column: assert property (
        @(posedge cfg_clk) disable iff (i_reset)
        i_timing.de |-> (i_timing.x < coord_t'(H_ACT))
    );

endmodule

`default_nettype wire

/* sample_measure.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_measure (
    input  wire                 cfg_clk,
    input  wire                 i_reset,
    input  logic                i_sample_valid,
    input  scope_pkg::sample_t  i_sample,
    output scope_pkg::meas_t    o_meas,
    output logic                o_meas_valid
);

    import scope_pkg::*;

    logic [CNT_W-1:0] win_cnt;  // samples seen in this window
    sample_t          prev_sample;
    sample_t          run_max;
    sample_t          run_min;
    logic [CNT_W-1:0] run_cross;

    logic             rising;
    sample_t          nxt_max;
    sample_t          nxt_min;
    logic [CNT_W-1:0] nxt_cross;

    always_comb
    begin
        rising = (i_sample >= sample_t'(MID_LEVEL)) && (prev_sample < sample_t'(MID_LEVEL));
        if (win_cnt == '0)
        begin
            // first sample of a window reseeds
            nxt_max   = i_sample;
            nxt_min   = i_sample;
            nxt_cross = CNT_W'(rising);
        end
        else
        begin
            nxt_max   = (i_sample > run_max) ? i_sample : run_max;
            nxt_min   = (i_sample < run_min) ? i_sample : run_min;
            nxt_cross = run_cross + CNT_W'(rising);
        end
    end

    // running values, seeded at window start
    always_ff @(posedge cfg_clk)
    begin
        if (i_sample_valid)
        begin
            run_max   <= nxt_max;
            run_min   <= nxt_min;
            run_cross <= nxt_cross;
        end
    end

    always_ff @(posedge cfg_clk)
    begin
        if (i_reset)
        begin
            win_cnt      <= '0;
            prev_sample  <= '0;
            o_meas       <= '0;
            o_meas_valid <= 1'b0;
        end
        else
        begin
            o_meas_valid <= 1'b0;
            if (i_sample_valid)
            begin
                prev_sample <= i_sample;  // carries across windows
                if (win_cnt == CNT_W'(MEAS_WINDOW - 1))
                begin
                    win_cnt          <= '0;
                    o_meas.max       <= nxt_max;
                    o_meas.min       <= nxt_min;
                    o_meas.crossings <= nxt_cross;
                    o_meas_valid     <= 1'b1;
                end
                else
                begin
                    win_cnt <= win_cnt + 1'b1;
                end
            end
        end
    end

    a_win_range: assert property (
        @(posedge cfg_clk) disable iff (i_reset)
        win_cnt < CNT_W'(MEAS_WINDOW)
    );

    a_valid_pulse: assert property (
        @(posedge cfg_clk) disable iff (i_reset)
        o_meas_valid |=> !o_meas_valid
    );

endmodule

`default_nettype wire

/* trace_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_buffer (
    input  wire                 cfg_clk,
    input  wire                 i_reset,
    input  logic                i_sample_valid,
    input  scope_pkg::sample_t  i_sample,
    input  logic                i_freeze,
    input  scope_pkg::coord_t   i_rd_addr,
    output scope_pkg::sample_t  o_rd_sample
);

    import scope_pkg::*;

    sample_t mem [H_ACT];  // one sample per screen column
    coord_t  wr_ptr;
    logic    wr_en;

    // freeze holds the capture on screen
    assign wr_en = i_sample_valid && !i_freeze && !i_reset;

    always_ff @(posedge cfg_clk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
        end
        else if (wr_en)
        begin
            if (wr_ptr == coord_t'(H_ACT - 1))
            begin
                wr_ptr <= '0;  // round robin
            end
            else
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge cfg_clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr[BUF_AW-1:0]] <= i_sample;
        end
    end

    // column read, data one cycle later
    always_ff @(posedge cfg_clk)
    begin
        o_rd_sample <= mem[i_rd_addr[BUF_AW-1:0]];  // blanking columns alias, unused
    end

    a_ptr_range: assert property (
        @(posedge cfg_clk) disable iff (i_reset)
        wr_ptr <= coord_t'(H_ACT - 1)
    );

endmodule

`default_nettype wire

/* video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire                 cfg_clk,
    input  wire                 i_reset,
    output scope_pkg::timing_t  o_timing
);

    import scope_pkg::*;

    coord_t h_cnt;  // pixel within line
    coord_t v_cnt;  // line within frame

    always_ff @(posedge cfg_clk)
    begin
        if (i_reset)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == coord_t'(H_TOTAL - 1))
        begin
            h_cnt <= '0;
            if (v_cnt == coord_t'(V_TOTAL - 1))
            begin
                v_cnt <= '0;  // frame wrap
            end
            else
            begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // sync and enable straight from the counters
    always_comb
    begin
        o_timing.de = (h_cnt < coord_t'(H_ACT)) && (v_cnt < coord_t'(V_ACT));
        o_timing.hs = (h_cnt >= coord_t'(H_ACT + H_FP)) &&
                      (h_cnt <  coord_t'(H_ACT + H_FP + H_SYNC));
        // vs spans whole lines
        o_timing.vs = (v_cnt >= coord_t'(V_ACT + V_FP)) &&
                      (v_cnt <  coord_t'(V_ACT + V_FP + V_SYNC));
        o_timing.x  = h_cnt;
        o_timing.y  = v_cnt;
    end

    // vsync only moves at the start of a line
    a_vs_line_start: assert property (
        @(posedge cfg_clk) disable iff (i_reset)
        $changed(o_timing.vs) |-> (o_timing.x == '0)
    );

    // hsync sits in horizontal blanking only
    a_hs_not_de: assert property (
        @(posedge cfg_clk) disable iff (i_reset)
        !(o_timing.hs && o_timing.de)
    );

endmodule

`default_nettype wire

/* scope_pkg.sv */
`default_nettype none

package scope_pkg;

    // raster timing, 64x64 active
    localparam int H_ACT   = 64;
    localparam int H_FP    = 4;
    localparam int H_SYNC  = 4;
    localparam int H_BP    = 8;
    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;  // 80 clocks per line

    localparam int V_ACT   = 64;
    localparam int V_FP    = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 4;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;  // 72 lines per frame

    localparam int COORD_W = 7;
    localparam int BUF_AW  = $clog2(H_ACT);  // trace buffer address bits

    // measurement
    localparam int SAMPLE_W    = 8;
    localparam int MID_LEVEL   = 128;  // crossing threshold
    localparam int MEAS_WINDOW = 256;
    localparam int CNT_W       = 9;

    // drawing
    localparam int GRID_STEP = 16;
    localparam int ROW_SHIFT = 2;  // 256 levels onto 64 rows

    // rgb565 colours
    localparam logic [15:0] COLOR_GRID  = 16'h8410;  // grey
    localparam logic [15:0] COLOR_TRACE = 16'hFFE0;  // yellow
    localparam logic [15:0] COLOR_BG    = 16'h0000;  // black
    localparam logic [15:0] COLOR_MAIN  = 16'h0010;  // dark blue

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [COORD_W-1:0]  coord_t;
    typedef logic [15:0]         pixel_t;

    // raw raster position and sync
    typedef struct packed {
        logic   vs;
        logic   hs;
        logic   de;
        coord_t x;
        coord_t y;
    } timing_t;

    // composed video word
    typedef struct packed {
        logic   vs;
        logic   hs;
        logic   de;
        pixel_t rgb;
    } video_t;

    // one window of results
    typedef struct packed {
        sample_t            max;
        sample_t            min;
        logic [CNT_W-1:0]   crossings;
    } meas_t;

    typedef enum logic {
        PAGE_MAIN = 1'b0,
        PAGE_WAVE = 1'b1
    } page_t;

endpackage

`default_nettype wire
